//--- common/serial_alu_consts.svh
`ifndef SERIAL_ALU_CONSTS_SVH
`define SERIAL_ALU_CONSTS_SVH

// operand and result width, one word
`define SERIAL_WIDTH 8

// bit counter, wide enough to count SERIAL_WIDTH bits
`define SERIAL_CNT_W 3

// wishbone data path
`define WB_DATA_W 32

// byte address, five registers of one word each
`define WB_ADR_W 5

`endif

//--- common/serial_alu_pkg.sv
package serial_alu_pkg;

    // operation code as held in CTRL bits 1:0
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_AND = 2'd2,
        OP_XOR = 2'd3
    } alu_op_t;

    // controller sequence for one operation
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_LOAD  = 3'd1,
        ST_SHIFT = 3'd2,
        ST_STORE = 3'd3,
        ST_DONE  = 3'd4
    } ctrl_state_t;

endpackage

//--- common/wb_map_pkg.sv
package wb_map_pkg;

    // word index, byte offset is index times four
    typedef enum logic [2:0] {
        REG_OPA    = 3'd0,
        REG_OPB    = 3'd1,
        REG_CTRL   = 3'd2,
        REG_STATUS = 3'd3,
        REG_RESULT = 3'd4
    } reg_idx_t;

    // STATUS bits
    localparam int STAT_BUSY  = 0;
    localparam int STAT_DONE  = 1;
    localparam int STAT_CARRY = 2;
    localparam int STAT_ZERO  = 3;

    // CTRL bits, op sits in 1:0
    localparam int CTRL_GO = 4;

endpackage

//--- serial_alu_top.f
+incdir+common
common/serial_alu_pkg.sv
common/wb_map_pkg.sv
source/wb_reg_decode.sv
serial_core/serial_controller.sv
serial_core/serial_datapath.sv
source/result_unit.sv
source/serial_alu_top.sv
verif/tb_serial_alu.sv

//--- serial_core/serial_controller.sv
`timescale 1ns/1ps

module serial_controller (
    input  logic clk,
    input  logic rst,
    input  logic go,
    input  logic bit_last,
    output logic load,
    output logic shift_en,
    output logic store,
    output logic busy
);

    serial_alu_pkg::ctrl_state_t ps;
    serial_alu_pkg::ctrl_state_t ns;

    always_comb begin
        ns = ps;
        case (ps)
            serial_alu_pkg::ST_IDLE: begin
                // go outside idle is dropped here
                ns = go ? serial_alu_pkg::ST_LOAD : serial_alu_pkg::ST_IDLE;
            end

            serial_alu_pkg::ST_LOAD: begin
                ns = serial_alu_pkg::ST_SHIFT;
            end

            serial_alu_pkg::ST_SHIFT: begin
                ns = bit_last ? serial_alu_pkg::ST_STORE : serial_alu_pkg::ST_SHIFT;
            end

            serial_alu_pkg::ST_STORE: begin
                ns = serial_alu_pkg::ST_DONE;
            end

            serial_alu_pkg::ST_DONE: begin
                ns = serial_alu_pkg::ST_IDLE;
            end

            default: begin
                ns = serial_alu_pkg::ST_IDLE;
            end
        endcase
    end

    always_comb begin
        load     = 1'b0;
        shift_en = 1'b0;
        store    = 1'b0;
        busy     = (ps != serial_alu_pkg::ST_IDLE);

        case (ps)
            serial_alu_pkg::ST_LOAD: begin
                load = 1'b1;
            end

            serial_alu_pkg::ST_SHIFT: begin
                shift_en = 1'b1;
            end

            serial_alu_pkg::ST_STORE: begin
                store = 1'b1;
            end

            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ps <= serial_alu_pkg::ST_IDLE;
        end else begin
            ps <= ns;
        end
    end

endmodule

//--- serial_core/serial_datapath.sv
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module serial_datapath (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load,
    input  logic                     shift_en,
    input  logic [`SERIAL_WIDTH-1:0] opa,
    input  logic [`SERIAL_WIDTH-1:0] opb,
    input  serial_alu_pkg::alu_op_t  op,
    output logic [`SERIAL_WIDTH-1:0] result_word,
    output logic                     carry_out,
    output logic                     bit_last
);

    localparam int LAST_BIT = `SERIAL_WIDTH - 1;

    logic [`SERIAL_WIDTH-1:0] a_sr;
    logic [`SERIAL_WIDTH-1:0] b_sr;
    logic [`SERIAL_WIDTH-1:0] res_sr;
    logic [`SERIAL_CNT_W-1:0] cnt;
    serial_alu_pkg::alu_op_t  op_q;
    logic                     carry_q;
    logic                     a_bit;
    logic                     b_bit;
    logic                     res_bit;
    logic                     carry_nxt;

    // subtract is A + ~B + 1, the +1 comes from the carry preset
    assign a_bit = a_sr[0];
    assign b_bit = (op_q == serial_alu_pkg::OP_SUB) ? ~b_sr[0] : b_sr[0];

    always_comb begin
        res_bit   = 1'b0;
        carry_nxt = 1'b0;
        case (op_q)
            serial_alu_pkg::OP_ADD, serial_alu_pkg::OP_SUB: begin
                res_bit   = a_bit ^ b_bit ^ carry_q;
                carry_nxt = (a_bit & b_bit) | (carry_q & (a_bit ^ b_bit));
            end
            serial_alu_pkg::OP_AND: res_bit = a_bit & b_bit;
            serial_alu_pkg::OP_XOR: res_bit = a_bit ^ b_bit;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            carry_q <= 1'b0;
            op_q    <= serial_alu_pkg::OP_ADD;
        end else if (load) begin
            cnt     <= '0;
            carry_q <= (op == serial_alu_pkg::OP_SUB);
            op_q    <= op;
        end else if (shift_en) begin
            cnt     <= cnt + 1'b1;
            carry_q <= carry_nxt;
        end
    end

    // lsb first in, new bit enters at the top
    always_ff @(posedge clk) begin
        if (load) begin
            a_sr <= opa;
            b_sr <= opb;
        end else if (shift_en) begin
            a_sr   <= a_sr >> 1;
            b_sr   <= b_sr >> 1;
            res_sr <= {res_bit, res_sr[`SERIAL_WIDTH-1:1]};
        end
    end

    assign bit_last    = (cnt == LAST_BIT[`SERIAL_CNT_W-1:0]);
    assign result_word = res_sr;
    assign carry_out   = carry_q;

endmodule

//--- source/result_unit.sv
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module result_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     store,
    input  logic                     go,
    input  logic                     done_clr,
    input  logic [`SERIAL_WIDTH-1:0] result_word,
    input  logic                     carry_out,
    output logic [`SERIAL_WIDTH-1:0] result,
    output logic                     carry,
    output logic                     zero,
    output logic                     done,
    output logic                     irq
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            carry <= 1'b0;
            zero  <= 1'b0;
            done  <= 1'b0;
        end else if (store) begin
            carry <= carry_out;
            zero  <= (result_word == '0);
            done  <= 1'b1;
        end else if (done_clr || go) begin
            done  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            result <= result_word;
        end
    end

    // level interrupt
    assign irq = done;

endmodule

//--- source/serial_alu_top.sv
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module serial_alu_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`WB_ADR_W-1:0]  wb_adr,
    input  logic [`WB_DATA_W-1:0] wb_dat_w,
    output logic [`WB_DATA_W-1:0] wb_dat_r,
    output logic                  wb_ack,
    output logic                  irq
);

    logic [`SERIAL_WIDTH-1:0] opa;
    logic [`SERIAL_WIDTH-1:0] opb;
    serial_alu_pkg::alu_op_t  op;
    logic                     go;
    logic                     done_clr;
    logic                     load;
    logic                     shift_en;
    logic                     store;
    logic                     busy;
    logic                     bit_last;
    logic [`SERIAL_WIDTH-1:0] result_word;
    logic                     carry_out;
    logic [`SERIAL_WIDTH-1:0] result;
    logic                     carry;
    logic                     zero;
    logic                     done;

    wb_reg_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .busy        (busy),
        .done        (done),
        .carry       (carry),
        .zero        (zero),
        .result_word (result),
        .opa         (opa),
        .opb         (opb),
        .op          (op),
        .go          (go),
        .done_clr    (done_clr)
    );

    serial_controller u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .go       (go),
        .bit_last (bit_last),
        .load     (load),
        .shift_en (shift_en),
        .store    (store),
        .busy     (busy)
    );

    serial_datapath u_datapath (
        .clk         (clk),
        .rst         (rst),
        .load        (load),
        .shift_en    (shift_en),
        .opa         (opa),
        .opb         (opb),
        .op          (op),
        .result_word (result_word),
        .carry_out   (carry_out),
        .bit_last    (bit_last)
    );

    result_unit u_result (
        .clk         (clk),
        .rst         (rst),
        .store       (store),
        .go          (go),
        .done_clr    (done_clr),
        .result_word (result_word),
        .carry_out   (carry_out),
        .result      (result),
        .carry       (carry),
        .zero        (zero),
        .done        (done),
        .irq         (irq)
    );

endmodule

//--- source/wb_reg_decode.sv
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module wb_reg_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [`WB_ADR_W-1:0]        wb_adr,
    input  logic [`WB_DATA_W-1:0]       wb_dat_w,
    output logic [`WB_DATA_W-1:0]       wb_dat_r,
    output logic                        wb_ack,
    input  logic                        busy,
    input  logic                        done,
    input  logic                        carry,
    input  logic                        zero,
    input  logic [`SERIAL_WIDTH-1:0]    result_word,
    output logic [`SERIAL_WIDTH-1:0]    opa,
    output logic [`SERIAL_WIDTH-1:0]    opb,
    output serial_alu_pkg::alu_op_t     op,
    output logic                        go,
    output logic                        done_clr
);

    wb_map_pkg::reg_idx_t  idx;
    logic                  req;
    logic                  wr_stb;
    logic [`WB_DATA_W-1:0] rd_data;

    // byte lanes are ignored
    assign idx = wb_map_pkg::reg_idx_t'(wb_adr[`WB_ADR_W-1:2]);

    // new request, ack follows one cycle later
    assign req = wb_cyc && wb_stb && !wb_ack;

    // writes land in the ack cycle
    assign wr_stb = wb_cyc && wb_stb && wb_we && wb_ack;

    assign go = wr_stb && (idx == wb_map_pkg::REG_CTRL)
                && wb_dat_w[wb_map_pkg::CTRL_GO];
    assign done_clr = wr_stb && (idx == wb_map_pkg::REG_STATUS)
                      && wb_dat_w[wb_map_pkg::STAT_DONE];

    always_comb begin
        rd_data = '0;
        case (idx)
            wb_map_pkg::REG_OPA:    rd_data[`SERIAL_WIDTH-1:0] = opa;
            wb_map_pkg::REG_OPB:    rd_data[`SERIAL_WIDTH-1:0] = opb;
            wb_map_pkg::REG_CTRL:   rd_data[1:0] = op;
            wb_map_pkg::REG_STATUS: begin
                rd_data[wb_map_pkg::STAT_BUSY]  = busy;
                rd_data[wb_map_pkg::STAT_DONE]  = done;
                rd_data[wb_map_pkg::STAT_CARRY] = carry;
                rd_data[wb_map_pkg::STAT_ZERO]  = zero;
            end
            wb_map_pkg::REG_RESULT: rd_data[`SERIAL_WIDTH-1:0] = result_word;
            // unmapped words read zero
            default:                rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack   <= req;
            wb_dat_r <= req ? rd_data : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opa <= '0;
            opb <= '0;
            op  <= serial_alu_pkg::OP_ADD;
        end else if (wr_stb) begin
            case (idx)
                wb_map_pkg::REG_OPA:  opa <= wb_dat_w[`SERIAL_WIDTH-1:0];
                wb_map_pkg::REG_OPB:  opb <= wb_dat_w[`SERIAL_WIDTH-1:0];
                wb_map_pkg::REG_CTRL: op  <= serial_alu_pkg::alu_op_t'(wb_dat_w[1:0]);
                default: ;
            endcase
        end
    end

endmodule

//--- verif/tb_serial_alu.sv
`timescale 1ns/1ps
`include "serial_alu_consts.svh"

module tb_serial_alu;

    localparam logic [`WB_ADR_W-1:0] ADR_OPA    = 5'h00;
    localparam logic [`WB_ADR_W-1:0] ADR_OPB    = 5'h04;
    localparam logic [`WB_ADR_W-1:0] ADR_CTRL   = 5'h08;
    localparam logic [`WB_ADR_W-1:0] ADR_STATUS = 5'h0C;
    localparam logic [`WB_ADR_W-1:0] ADR_RESULT = 5'h10;
    localparam logic [`WB_ADR_W-1:0] ADR_HOLE_A = 5'h14;
    localparam logic [`WB_ADR_W-1:0] ADR_HOLE_B = 5'h1C;

    // about 80 operations of roughly 22 cycles each make near 1800 cycles
    localparam int MAX_CYCLES = 5000;

    localparam logic [31:0] GO_BIT = 32'd1 << wb_map_pkg::CTRL_GO;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADR_W-1:0]  wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    logic [`WB_DATA_W-1:0] wb_dat_r;
    logic                  wb_ack;
    logic                  irq;
    int                    cycles = 0;
    string                 test_name;

    serial_alu_top uut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("*** FAILED ***");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // entered and left on a falling edge
    task automatic wb_write(input logic [`WB_ADR_W-1:0] adr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        // write lands on the edge that closes the ack cycle
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [`WB_ADR_W-1:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        data = wb_dat_r;
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // {carry, result} as the host should see them
    function automatic logic [8:0] expected_outcome(input logic [1:0] op,
                                                    input logic [7:0] a,
                                                    input logic [7:0] b);
        logic [8:0] out;
        case (op)
            serial_alu_pkg::OP_ADD: out = {1'b0, a} + {1'b0, b};
            serial_alu_pkg::OP_SUB: out = {(a >= b), a - b};
            serial_alu_pkg::OP_AND: out = {1'b0, a & b};
            default:                out = {1'b0, a ^ b};
        endcase
        return out;
    endfunction

    task automatic start_op(input logic [1:0] op, input logic [7:0] a, input logic [7:0] b);
        wb_write(ADR_OPA, {24'h0, a});
        wb_write(ADR_OPB, {24'h0, b});
        wb_write(ADR_CTRL, GO_BIT | 32'(op));
    endtask

    task automatic wait_done();
        logic [31:0] d;
        d = '0;
        while (!d[wb_map_pkg::STAT_DONE]) begin
            wb_read(ADR_STATUS, d);
        end
    endtask

    task automatic check_result(input logic [1:0] op, input logic [7:0] a,
                                input logic [7:0] b);
        logic [8:0]  exp;
        logic [31:0] d;
        exp = expected_outcome(op, a, b);
        wb_read(ADR_RESULT, d);
        check($sformatf("result op %0d a %0h b %0h", op, a, b), {24'h0, exp[7:0]}, d);
        wb_read(ADR_STATUS, d);
        check($sformatf("carry op %0d a %0h b %0h", op, a, b), exp[8],
              d[wb_map_pkg::STAT_CARRY]);
        check($sformatf("zero op %0d a %0h b %0h", op, a, b), exp[7:0] == 8'h00,
              d[wb_map_pkg::STAT_ZERO]);
        check("done after op", 1, d[wb_map_pkg::STAT_DONE]);
    endtask

    task automatic run_op(input logic [1:0] op, input logic [7:0] a, input logic [7:0] b);
        start_op(op, a, b);
        wait_done();
        check_result(op, a, b);
    endtask

    task automatic run_random(input logic [1:0] op, input int count);
        logic [7:0] a;
        logic [7:0] b;
        repeat (count) begin
            a = 8'($urandom);
            b = 8'($urandom);
            run_op(op, a, b);
        end
    endtask

    task automatic test_regs();
        logic [31:0] d;
        test_name = "regs";
        wb_read(ADR_STATUS, d);
        check("status after reset", 0, d);
        check("irq after reset", 0, irq);
        wb_write(ADR_OPA, 32'h1234_56a5);
        wb_write(ADR_OPB, 32'hffff_ff3c);
        wb_read(ADR_OPA, d);
        check("opa readback", 32'h0000_00a5, d);
        wb_read(ADR_OPB, d);
        check("opb readback", 32'h0000_003c, d);
        wb_write(ADR_HOLE_A, 32'hffff_ffff);
        wb_read(ADR_HOLE_A, d);
        check("unmapped 0x14", 0, d);
        wb_read(ADR_HOLE_B, d);
        check("unmapped 0x1c", 0, d);
        wb_read(ADR_OPA, d);
        check("opa after unmapped write", 32'h0000_00a5, d);
    endtask

    task automatic test_add();
        test_name = "add";
        run_op(serial_alu_pkg::OP_ADD, 8'd0, 8'd0);
        run_op(serial_alu_pkg::OP_ADD, 8'd255, 8'd1);
        run_op(serial_alu_pkg::OP_ADD, 8'd200, 8'd100);
        run_random(serial_alu_pkg::OP_ADD, 20);
    endtask

    task automatic test_sub();
        test_name = "sub";
        run_op(serial_alu_pkg::OP_SUB, 8'd77, 8'd77);
        run_op(serial_alu_pkg::OP_SUB, 8'd5, 8'd9);
        run_op(serial_alu_pkg::OP_SUB, 8'd9, 8'd5);
        run_random(serial_alu_pkg::OP_SUB, 20);
    endtask

    task automatic test_logic();
        test_name = "and_xor";
        run_op(serial_alu_pkg::OP_AND, 8'hf0, 8'h0f);
        run_op(serial_alu_pkg::OP_AND, 8'hff, 8'ha5);
        run_op(serial_alu_pkg::OP_XOR, 8'h5a, 8'h5a);
        run_op(serial_alu_pkg::OP_XOR, 8'h0f, 8'hff);
        run_random(serial_alu_pkg::OP_AND, 10);
        run_random(serial_alu_pkg::OP_XOR, 10);
    endtask

    task automatic test_control();
        logic [31:0] d;
        test_name = "control";
        // operands chosen so that add and xor differ
        start_op(serial_alu_pkg::OP_ADD, 8'd100, 8'd60);
        wb_read(ADR_STATUS, d);
        check("busy after go", 1, d[wb_map_pkg::STAT_BUSY]);
        // second go with another op is dropped
        wb_write(ADR_CTRL, GO_BIT | 32'(serial_alu_pkg::OP_XOR));
        wait_done();
        check_result(serial_alu_pkg::OP_ADD, 8'd100, 8'd60);
        wb_read(ADR_STATUS, d);
        check("busy after dropped go", 0, d[wb_map_pkg::STAT_BUSY]);

        start_op(serial_alu_pkg::OP_SUB, 8'd50, 8'd20);
        wb_write(ADR_OPA, 32'd3);
        wb_write(ADR_OPB, 32'd200);
        wait_done();
        check_result(serial_alu_pkg::OP_SUB, 8'd50, 8'd20);
        // operands written during the last run
        wb_write(ADR_CTRL, GO_BIT | 32'(serial_alu_pkg::OP_SUB));
        wait_done();
        check_result(serial_alu_pkg::OP_SUB, 8'd3, 8'd200);
    endtask

    task automatic test_done_irq();
        logic [31:0] d;
        test_name = "done_irq";
        run_op(serial_alu_pkg::OP_XOR, 8'h3c, 8'h0f);
        check("irq after op", 1, irq);
        wb_write(ADR_STATUS, 32'd1 << wb_map_pkg::STAT_DONE);
        wb_read(ADR_STATUS, d);
        check("done after clear", 0, d[wb_map_pkg::STAT_DONE]);
        check("irq after clear", 0, irq);

        run_op(serial_alu_pkg::OP_AND, 8'h96, 8'h3f);
        check("irq after second op", 1, irq);
        wb_write(ADR_CTRL, GO_BIT | 32'(serial_alu_pkg::OP_ADD));
        wb_read(ADR_STATUS, d);
        check("done after new go", 0, d[wb_map_pkg::STAT_DONE]);
        check("busy after new go", 1, d[wb_map_pkg::STAT_BUSY]);
        check("irq after new go", 0, irq);
        wait_done();
        check_result(serial_alu_pkg::OP_ADD, 8'h96, 8'h3f);
        check("irq at end", 1, irq);
    endtask

    initial begin
        int seed_ret;
        clk       = 1'b0;
        rst       = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        test_name = "reset";
        seed_ret  = $urandom(32'h1e802926);
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_regs();
        test_add();
        test_sub();
        test_logic();
        test_control();
        test_done_irq();

        $display("*** PASSED ***");
        $finish;
    end

endmodule
